// File: Makefile
TOP := tb_mips_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: all.f
common/mips_isa_pkg.sv
common/mips_ctrl_pkg.sv
datapath/alu.sv
datapath/reg_file.sv
datapath/pc_unit.sv
datapath/data_path.sv
rtl/control_unit.sv
rtl/mips_core.sv
bench/tb_clock.sv
bench/tb_mips_core.sv

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: bench/tb_mips_core.sv
module tb_mips_core;

    localparam logic [31:0] RESET_PC     = 32'h0;
    localparam int          PERIOD       = 100;
    localparam int          RESET_CYCLES = 8;
    localparam int          N_TESTS      = 6;
    localparam int          TEST_CYCLES  = 64;

    logic        clk;
    logic        clk_rst_n;
    logic        test_rst_n;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] mem_rdata;
    logic [31:0] inst_addr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;
    logic        halted;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_q [$];
    logic [31:0] lfsr;
    int          prog_len;

    tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_clock (
        .clk   (clk),
        .rst_n (clk_rst_n)
    );

    assign rst_n     = clk_rst_n && test_rst_n;
    assign inst      = imem[inst_addr[9:2]];
    assign mem_rdata = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    mips_core #(.RESET_PC(RESET_PC)) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst      (inst),
        .mem_rdata (mem_rdata),
        .inst_addr (inst_addr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .halted    (halted)
    );

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = 32'b0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(int idx);
        return 32'hbad0_0000 + 32'(idx); // Unwritten data slots.
    endfunction

    function automatic logic [31:0] enc_r(mips_isa_pkg::funct_e fn, logic [4:0] rs,
                                          logic [4:0] rt, logic [4:0] rd, logic [4:0] sh);
        return {mips_isa_pkg::OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(mips_isa_pkg::opcode_e op, logic [4:0] rs,
                                          logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(mips_isa_pkg::opcode_e op, logic [25:0] target);
        return {op, target};
    endfunction

    task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic clear_memories();
        // Unused code slots hold syscall with the address in its code field.
        for (int i = 0; i < 256; i++) begin
            imem[i] = {mips_isa_pkg::OP_RTYPE, 20'(i), mips_isa_pkg::FN_SYSCALL};
            dmem[i] = fill_word(i);
        end
        prog_len = 0;
        exp_q.delete();
    endtask

    task automatic emit(logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic emit_li(logic [4:0] r, logic [31:0] value);
        emit(enc_i(mips_isa_pkg::OP_LUI, 5'd0, r, value[31:16]));
        emit(enc_i(mips_isa_pkg::OP_ORI, r, r, value[15:0]));
    endtask

    // Stores r3 into the next result slot.
    task automatic alu_step(logic [31:0] word, logic [31:0] expected);
        emit(word);
        emit(enc_i(mips_isa_pkg::OP_SW, 5'd0, 5'd3, 16'(exp_q.size() * 4)));
        exp_q.push_back(expected);
    endtask

    task automatic run_program();
        @(posedge clk);
        test_rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        test_rst_n <= 1'b1;
        @(negedge clk);
        while (!halted) @(negedge clk);
    endtask

    task automatic check_results();
        for (int k = 0; k < exp_q.size(); k++) begin
            check_word($sformatf("dmem[%0d]", k), exp_q[k], dmem[k]);
        end
    endtask

    task automatic test_reset();
        clear_memories();
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 0, 16'd0)); // Store at the reset PC.
        emit(enc_r(mips_isa_pkg::FN_SYSCALL, 0, 0, 0, 0));
        @(negedge clk);
        while (!halted) @(negedge clk);
        @(posedge clk);
        test_rst_n <= 1'b0;
        @(negedge clk);
        check_word("inst_addr", RESET_PC, inst_addr);
        check_flag("mem_we", 1'b0, mem_we);
        check_flag("halted", 1'b0, halted);
        repeat (RESET_CYCLES) @(posedge clk);
        test_rst_n <= 1'b1;
        @(negedge clk);
        check_word("inst_addr", RESET_PC, inst_addr);
        check_flag("halted", 1'b0, halted);
        while (!halted) @(negedge clk);
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [4:0]  sh;
        logic [31:0] se;
        logic [31:0] ze;
        a   = rand_bits(32);
        b   = rand_bits(32);
        imm = 16'(rand_bits(16));
        sh  = 5'(rand_bits(5));
        se  = {{16{imm[15]}}, imm};
        ze  = {16'b0, imm};
        clear_memories();
        emit_li(5'd1, a);
        emit_li(5'd2, b);
        alu_step(enc_r(mips_isa_pkg::FN_ADD, 1, 2, 3, 0), a + b);
        alu_step(enc_r(mips_isa_pkg::FN_ADDU, 1, 2, 3, 0), a + b);
        alu_step(enc_r(mips_isa_pkg::FN_SUB, 1, 2, 3, 0), a - b);
        alu_step(enc_r(mips_isa_pkg::FN_SUBU, 1, 2, 3, 0), a - b);
        alu_step(enc_r(mips_isa_pkg::FN_AND, 1, 2, 3, 0), a & b);
        alu_step(enc_r(mips_isa_pkg::FN_OR, 1, 2, 3, 0), a | b);
        alu_step(enc_r(mips_isa_pkg::FN_XOR, 1, 2, 3, 0), a ^ b);
        alu_step(enc_r(mips_isa_pkg::FN_NOR, 1, 2, 3, 0), ~(a | b));
        alu_step(enc_r(mips_isa_pkg::FN_SLT, 1, 2, 3, 0), 32'($signed(a) < $signed(b)));
        alu_step(enc_r(mips_isa_pkg::FN_SLTU, 1, 2, 3, 0), 32'(a < b));
        alu_step(enc_r(mips_isa_pkg::FN_SLL, 0, 2, 3, sh), b << sh);
        alu_step(enc_r(mips_isa_pkg::FN_SRL, 0, 2, 3, sh), b >> sh);
        alu_step(enc_r(mips_isa_pkg::FN_SRA, 0, 2, 3, sh),
                 (b >> sh) | (~(32'hffff_ffff >> sh) & {32{b[31]}}));
        alu_step(enc_i(mips_isa_pkg::OP_ADDI, 1, 3, imm), a + se);
        alu_step(enc_i(mips_isa_pkg::OP_ADDIU, 1, 3, imm), a + se);
        alu_step(enc_i(mips_isa_pkg::OP_ANDI, 1, 3, imm), a & ze);
        alu_step(enc_i(mips_isa_pkg::OP_ORI, 1, 3, imm), a | ze);
        alu_step(enc_i(mips_isa_pkg::OP_XORI, 1, 3, imm), a ^ ze);
        alu_step(enc_i(mips_isa_pkg::OP_SLTI, 1, 3, imm), 32'($signed(a) < $signed(se)));
        alu_step(enc_i(mips_isa_pkg::OP_SLTIU, 1, 3, imm), 32'(a < se));
        alu_step(enc_i(mips_isa_pkg::OP_LUI, 0, 3, imm), {imm, 16'b0});
        emit(enc_r(mips_isa_pkg::FN_SYSCALL, 0, 0, 0, 0));
        run_program();
        check_results();
    endtask

    task automatic test_load_store();
        logic [31:0] v;
        v = rand_bits(32);
        clear_memories();
        emit_li(5'd1, v);
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 1, 16'd0));
        emit(enc_i(mips_isa_pkg::OP_LW, 0, 4, 16'd0));
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 4, 16'd4));
        emit(enc_i(mips_isa_pkg::OP_ADDIU, 1, 0, 16'd5)); // Write to $0 is dropped.
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 0, 16'd8));
        emit(enc_r(mips_isa_pkg::FN_SYSCALL, 0, 0, 0, 0));
        exp_q.push_back(v);
        exp_q.push_back(v);
        exp_q.push_back(32'h0);
        run_program();
        check_results();
    endtask

    task automatic branch_case(mips_isa_pkg::opcode_e op, logic [4:0] rs, logic [4:0] rt,
                               logic [31:0] rs_val, logic [31:0] rt_val);
        logic taken;
        case (op)
            mips_isa_pkg::OP_BEQ:  taken = (rs_val == rt_val);
            mips_isa_pkg::OP_BNE:  taken = (rs_val != rt_val);
            mips_isa_pkg::OP_BLEZ: taken = ($signed(rs_val) <= 0);
            default:               taken = ($signed(rs_val) > 0);
        endcase
        emit(enc_i(op, rs, rt, 16'd1)); // Target skips the marker store.
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 9, 16'(exp_q.size() * 4)));
        exp_q.push_back(taken ? fill_word(exp_q.size()) : 32'h0000_00a5);
    endtask

    task automatic test_branches();
        clear_memories();
        emit(enc_i(mips_isa_pkg::OP_ADDIU, 0, 1, 16'd5));
        emit(enc_i(mips_isa_pkg::OP_ADDIU, 0, 2, 16'd5));
        emit(enc_i(mips_isa_pkg::OP_ADDIU, 0, 3, 16'hfffd));
        emit(enc_i(mips_isa_pkg::OP_ADDIU, 0, 9, 16'h00a5));
        branch_case(mips_isa_pkg::OP_BEQ, 1, 2, 32'd5, 32'd5);
        branch_case(mips_isa_pkg::OP_BEQ, 1, 3, 32'd5, -32'sd3);
        branch_case(mips_isa_pkg::OP_BNE, 1, 3, 32'd5, -32'sd3);
        branch_case(mips_isa_pkg::OP_BNE, 1, 2, 32'd5, 32'd5);
        branch_case(mips_isa_pkg::OP_BLEZ, 3, 0, -32'sd3, 32'd0);
        branch_case(mips_isa_pkg::OP_BLEZ, 0, 0, 32'd0, 32'd0);
        branch_case(mips_isa_pkg::OP_BLEZ, 1, 0, 32'd5, 32'd0);
        branch_case(mips_isa_pkg::OP_BGTZ, 1, 0, 32'd5, 32'd0);
        branch_case(mips_isa_pkg::OP_BGTZ, 0, 0, 32'd0, 32'd0);
        branch_case(mips_isa_pkg::OP_BGTZ, 3, 0, -32'sd3, 32'd0);
        emit(enc_r(mips_isa_pkg::FN_SYSCALL, 0, 0, 0, 0));
        run_program();
        check_results();
    endtask

    task automatic test_jumps();
        clear_memories();
        emit(enc_i(mips_isa_pkg::OP_ADDIU, 0, 9, 16'h0077));
        emit(enc_j(mips_isa_pkg::OP_J, 26'd3));
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 9, 16'd0));
        emit(enc_j(mips_isa_pkg::OP_JAL, 26'd6)); // Link value is 16.
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 9, 16'd4));
        emit(enc_r(mips_isa_pkg::FN_SYSCALL, 0, 0, 0, 0));
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 31, 16'd8));
        emit(enc_r(mips_isa_pkg::FN_JR, 31, 0, 0, 0));
        exp_q.push_back(fill_word(0));
        exp_q.push_back(32'h0000_0077);
        exp_q.push_back(32'd16);
        run_program();
        check_results();
    endtask

    task automatic test_halt();
        clear_memories();
        emit(enc_i(mips_isa_pkg::OP_ADDIU, 0, 9, 16'h0055));
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 9, 16'd0));
        emit(enc_r(mips_isa_pkg::FN_SYSCALL, 0, 0, 0, 0));
        emit(enc_i(mips_isa_pkg::OP_SW, 0, 9, 16'd4));
        exp_q.push_back(32'h0000_0055);
        exp_q.push_back(fill_word(1));
        run_program();
        // A store now sits at the halted PC and must not run.
        @(posedge clk);
        imem[inst_addr[9:2]] <= enc_i(mips_isa_pkg::OP_SW, 0, 9, 16'd4);
        @(negedge clk);
        repeat (6) begin
            check_flag("halted", 1'b1, halted);
            check_flag("mem_we", 1'b0, mem_we);
            check_word("inst_addr", RESET_PC + 32'd8, inst_addr);
            @(negedge clk);
        end
        check_results();
    endtask

    initial begin
        #((N_TESTS * (TEST_CYCLES + RESET_CYCLES) + RESET_CYCLES) * PERIOD);
        $display("Watchdog expired because the core never halted");
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        lfsr       = 32'd63;
        test_rst_n = 1'b1;
        clear_memories();
        @(posedge clk_rst_n);
        test_reset();
        test_alu();
        test_load_store();
        test_branches();
        test_jumps();
        test_halt();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: common/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK // PC+4, no delay slot.
    } wb_src_e;

    typedef enum logic [2:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JUMP,
        PC_REG,
        PC_HOLD
    } pc_src_e;

    typedef enum logic {
        ST_RUN,
        ST_HALT
    } core_state_e;

endpackage

// File: common/mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int REG_W    = 5;
    localparam int SHAMT_W  = 5;
    localparam int IMM_W    = 16;
    localparam int TARGET_W = 26;

    localparam logic [REG_W-1:0] LINK_REG = 5'd31; // Written by jal.

    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_BLEZ  = 6'h06,
        OP_BGTZ  = 6'h07,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_SRA     = 6'h03,
        FN_JR      = 6'h08,
        FN_SYSCALL = 6'h0c,
        FN_ADD     = 6'h20,
        FN_ADDU    = 6'h21,
        FN_SUB     = 6'h22,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_NOR     = 6'h27,
        FN_SLT     = 6'h2a,
        FN_SLTU    = 6'h2b
    } funct_e;

endpackage

// File: datapath/alu.sv
module alu (
    input  mips_ctrl_pkg::alu_op_e alu_op,
    input  logic [31:0]            a,
    input  logic [31:0]            b,
    output logic [31:0]            result,
    output logic                   zero,
    output logic                   negative
);

    logic [4:0] sh;

    assign sh = a[4:0]; // Shift count from shamt field.

    always_comb begin
        case (alu_op)
            mips_ctrl_pkg::ALU_ADD:  result = a + b;
            mips_ctrl_pkg::ALU_SUB:  result = a - b;
            mips_ctrl_pkg::ALU_AND:  result = a & b;
            mips_ctrl_pkg::ALU_OR:   result = a | b;
            mips_ctrl_pkg::ALU_XOR:  result = a ^ b;
            mips_ctrl_pkg::ALU_NOR:  result = ~(a | b);
            mips_ctrl_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            mips_ctrl_pkg::ALU_SLTU: result = {31'b0, a < b};
            mips_ctrl_pkg::ALU_SLL:  result = b << sh;
            mips_ctrl_pkg::ALU_SRL:  result = b >> sh;
            mips_ctrl_pkg::ALU_SRA:  result = $unsigned($signed(b) >>> sh);
            mips_ctrl_pkg::ALU_LUI:  result = {b[15:0], 16'b0};
            default:                 result = 32'b0;
        endcase
    end

    assign zero     = (result == 32'b0);
    assign negative = result[31];

endmodule

// File: datapath/data_path.sv
module data_path #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [31:0]            inst,
    input  mips_ctrl_pkg::alu_op_e alu_op,
    input  logic                   alu_src_imm,
    input  logic                   shift_src_shamt,
    input  logic                   imm_unsigned,
    input  logic                   reg_dst_rd,
    input  logic                   reg_we,
    input  mips_ctrl_pkg::wb_src_e wb_src,
    input  mips_ctrl_pkg::pc_src_e pc_src,
    input  logic [31:0]            mem_rdata,
    output mips_isa_pkg::opcode_e  opcode,
    output mips_isa_pkg::funct_e   funct,
    output logic                   zero,
    output logic                   negative,
    output logic [31:0]            inst_addr,
    output logic [31:0]            mem_addr,
    output logic [31:0]            mem_wdata
);

    logic [mips_isa_pkg::REG_W-1:0]   rs_num;
    logic [mips_isa_pkg::REG_W-1:0]   rt_num;
    logic [mips_isa_pkg::REG_W-1:0]   rd_field;
    logic [mips_isa_pkg::REG_W-1:0]   dst_num;
    logic [mips_isa_pkg::SHAMT_W-1:0] shamt;
    logic [mips_isa_pkg::IMM_W-1:0]   imm16;
    logic [31:0]                      imm_ext;
    logic [31:0]                      rs_data;
    logic [31:0]                      rt_data;
    logic [31:0]                      alu_a;
    logic [31:0]                      alu_b;
    logic [31:0]                      alu_result;
    logic [31:0]                      wb_data;
    logic [31:0]                      pc_plus4;

    assign opcode   = mips_isa_pkg::opcode_e'(inst[31:26]);
    assign funct    = mips_isa_pkg::funct_e'(inst[5:0]);
    assign rs_num   = inst[25:21];
    assign rt_num   = inst[20:16];
    assign rd_field = inst[15:11];
    assign shamt    = inst[10:6];
    assign imm16    = inst[15:0];

    assign imm_ext = imm_unsigned ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
    assign alu_a   = shift_src_shamt ? {{(32 - mips_isa_pkg::SHAMT_W){1'b0}}, shamt} : rs_data;
    assign alu_b   = alu_src_imm ? imm_ext : rt_data;

    // Only jal writes back the link value.
    assign dst_num = (wb_src == mips_ctrl_pkg::WB_LINK) ? mips_isa_pkg::LINK_REG :
                     reg_dst_rd                         ? rd_field : rt_num;

    always_comb begin
        case (wb_src)
            mips_ctrl_pkg::WB_MEM:  wb_data = mem_rdata;
            mips_ctrl_pkg::WB_LINK: wb_data = pc_plus4;
            default:                wb_data = alu_result;
        endcase
    end

    assign mem_addr  = alu_result;
    assign mem_wdata = rt_data;

    alu i_alu (
        .alu_op   (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .result   (alu_result),
        .zero     (zero),
        .negative (negative)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rd_num  (dst_num),
        .rd_data (wb_data),
        .rd_we   (reg_we),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) i_pc_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc_src   (pc_src),
        .imm16    (imm16),
        .target26 (inst[25:0]),
        .rs_data  (rs_data),
        .pc       (inst_addr),
        .pc_plus4 (pc_plus4)
    );

endmodule

// File: datapath/pc_unit.sv
module pc_unit #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  mips_ctrl_pkg::pc_src_e            pc_src,
    input  logic [mips_isa_pkg::IMM_W-1:0]    imm16,
    input  logic [mips_isa_pkg::TARGET_W-1:0] target26,
    input  logic [31:0]                       rs_data,
    output logic [31:0]                       pc,
    output logic [31:0]                       pc_plus4
);

    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] pc_next;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jump_target   = {pc_plus4[31:28], target26, 2'b00}; // Same 256 MB region.

    always_comb begin
        case (pc_src)
            mips_ctrl_pkg::PC_BRANCH: pc_next = branch_target;
            mips_ctrl_pkg::PC_JUMP:   pc_next = jump_target;
            mips_ctrl_pkg::PC_REG:    pc_next = rs_data;
            mips_ctrl_pkg::PC_HOLD:   pc_next = pc;
            default:                  pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: datapath/reg_file.sv
module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mips_isa_pkg::REG_W-1:0] rs_num,
    input  logic [mips_isa_pkg::REG_W-1:0] rt_num,
    input  logic [mips_isa_pkg::REG_W-1:0] rd_num,
    input  logic [31:0]                    rd_data,
    input  logic                           rd_we,
    output logic [31:0]                    rs_data,
    output logic [31:0]                    rt_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (rd_we && rd_num != '0) begin
            regs[rd_num] <= rd_data;
        end
    end

    // $zero reads as zero regardless of writes.
    assign rs_data = (rs_num == '0) ? 32'b0 : regs[rs_num];
    assign rt_data = (rt_num == '0) ? 32'b0 : regs[rt_num];

endmodule

// File: rtl/control_unit.sv
module control_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mips_isa_pkg::opcode_e  opcode,
    input  mips_isa_pkg::funct_e   funct,
    input  logic                   zero,
    input  logic                   negative,
    output mips_ctrl_pkg::alu_op_e alu_op,
    output logic                   alu_src_imm,
    output logic                   shift_src_shamt,
    output logic                   imm_unsigned,
    output logic                   reg_dst_rd,
    output logic                   reg_we,
    output logic                   mem_we,
    output mips_ctrl_pkg::wb_src_e wb_src,
    output mips_ctrl_pkg::pc_src_e pc_src,
    output logic                   halted
);

    mips_ctrl_pkg::core_state_e state;
    mips_ctrl_pkg::pc_src_e     pc_src_dec;
    logic                       reg_we_dec;
    logic                       mem_we_dec;
    logic                       syscall_dec;
    logic                       write_ok;

    always_comb begin
        alu_op          = mips_ctrl_pkg::ALU_ADD;
        alu_src_imm     = 1'b0;
        shift_src_shamt = 1'b0;
        imm_unsigned    = 1'b0;
        reg_dst_rd      = 1'b0;
        reg_we_dec      = 1'b0;
        mem_we_dec      = 1'b0;
        wb_src          = mips_ctrl_pkg::WB_ALU;
        pc_src_dec      = mips_ctrl_pkg::PC_SEQ;
        syscall_dec     = 1'b0;
        case (opcode)
            mips_isa_pkg::OP_RTYPE: begin
                reg_dst_rd = 1'b1;
                reg_we_dec = 1'b1;
                case (funct)
                    mips_isa_pkg::FN_SLL: begin
                        alu_op          = mips_ctrl_pkg::ALU_SLL;
                        shift_src_shamt = 1'b1;
                    end
                    mips_isa_pkg::FN_SRL: begin
                        alu_op          = mips_ctrl_pkg::ALU_SRL;
                        shift_src_shamt = 1'b1;
                    end
                    mips_isa_pkg::FN_SRA: begin
                        alu_op          = mips_ctrl_pkg::ALU_SRA;
                        shift_src_shamt = 1'b1;
                    end
                    mips_isa_pkg::FN_JR: begin
                        reg_we_dec = 1'b0;
                        pc_src_dec = mips_ctrl_pkg::PC_REG;
                    end
                    mips_isa_pkg::FN_SYSCALL: begin
                        reg_we_dec  = 1'b0;
                        syscall_dec = 1'b1;
                    end
                    mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU: alu_op = mips_ctrl_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUB, mips_isa_pkg::FN_SUBU: alu_op = mips_ctrl_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  alu_op = mips_ctrl_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   alu_op = mips_ctrl_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  alu_op = mips_ctrl_pkg::ALU_XOR;
                    mips_isa_pkg::FN_NOR:  alu_op = mips_ctrl_pkg::ALU_NOR;
                    mips_isa_pkg::FN_SLT:  alu_op = mips_ctrl_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLTU: alu_op = mips_ctrl_pkg::ALU_SLTU;
                    default: reg_we_dec = 1'b0; // Unknown funct is a no-op.
                endcase
            end
            mips_isa_pkg::OP_J:   pc_src_dec = mips_ctrl_pkg::PC_JUMP;
            mips_isa_pkg::OP_JAL: begin
                reg_we_dec = 1'b1;
                wb_src     = mips_ctrl_pkg::WB_LINK;
                pc_src_dec = mips_ctrl_pkg::PC_JUMP;
            end
            // Branches compare rs against rt; blez and bgtz encode rt as $0.
            mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE,
            mips_isa_pkg::OP_BLEZ, mips_isa_pkg::OP_BGTZ: begin
                alu_op = mips_ctrl_pkg::ALU_SUB;
                if ((opcode == mips_isa_pkg::OP_BEQ  && zero) ||
                    (opcode == mips_isa_pkg::OP_BNE  && !zero) ||
                    (opcode == mips_isa_pkg::OP_BLEZ && (zero || negative)) ||
                    (opcode == mips_isa_pkg::OP_BGTZ && !zero && !negative)) begin
                    pc_src_dec = mips_ctrl_pkg::PC_BRANCH;
                end
            end
            mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_ADDIU: begin
                alu_src_imm = 1'b1;
                reg_we_dec  = 1'b1;
            end
            mips_isa_pkg::OP_SLTI, mips_isa_pkg::OP_SLTIU: begin
                alu_op      = (opcode == mips_isa_pkg::OP_SLTI) ? mips_ctrl_pkg::ALU_SLT
                                                                : mips_ctrl_pkg::ALU_SLTU;
                alu_src_imm = 1'b1;
                reg_we_dec  = 1'b1;
            end
            mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI: begin
                alu_op       = (opcode == mips_isa_pkg::OP_ANDI) ? mips_ctrl_pkg::ALU_AND :
                               (opcode == mips_isa_pkg::OP_ORI)  ? mips_ctrl_pkg::ALU_OR  :
                                                                   mips_ctrl_pkg::ALU_XOR;
                alu_src_imm  = 1'b1;
                imm_unsigned = 1'b1;
                reg_we_dec   = 1'b1;
            end
            mips_isa_pkg::OP_LUI: begin
                alu_op      = mips_ctrl_pkg::ALU_LUI;
                alu_src_imm = 1'b1;
                reg_we_dec  = 1'b1;
            end
            mips_isa_pkg::OP_LW: begin
                alu_src_imm = 1'b1;
                reg_we_dec  = 1'b1;
                wb_src      = mips_ctrl_pkg::WB_MEM;
            end
            mips_isa_pkg::OP_SW: begin
                alu_src_imm = 1'b1;
                mem_we_dec  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mips_ctrl_pkg::ST_RUN;
        end else if (syscall_dec) begin
            state <= mips_ctrl_pkg::ST_HALT; // Sticky until reset.
        end
    end

    assign halted   = (state == mips_ctrl_pkg::ST_HALT);
    assign write_ok = rst_n && !halted;
    assign reg_we   = reg_we_dec && write_ok;
    assign mem_we   = mem_we_dec && write_ok;
    assign pc_src   = (halted || syscall_dec) ? mips_ctrl_pkg::PC_HOLD : pc_src_dec;

endmodule

// File: rtl/mips_core.sv
module mips_core #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] inst,
    input  logic [31:0] mem_rdata,
    output logic [31:0] inst_addr,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic        mem_we,
    output logic        halted
);

    mips_isa_pkg::opcode_e  opcode;
    mips_isa_pkg::funct_e   funct;
    mips_ctrl_pkg::alu_op_e alu_op;
    mips_ctrl_pkg::wb_src_e wb_src;
    mips_ctrl_pkg::pc_src_e pc_src;
    logic                   zero;
    logic                   negative;
    logic                   alu_src_imm;
    logic                   shift_src_shamt;
    logic                   imm_unsigned;
    logic                   reg_dst_rd;
    logic                   reg_we;

    control_unit i_control_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .opcode          (opcode),
        .funct           (funct),
        .zero            (zero),
        .negative        (negative),
        .alu_op          (alu_op),
        .alu_src_imm     (alu_src_imm),
        .shift_src_shamt (shift_src_shamt),
        .imm_unsigned    (imm_unsigned),
        .reg_dst_rd      (reg_dst_rd),
        .reg_we          (reg_we),
        .mem_we          (mem_we),
        .wb_src          (wb_src),
        .pc_src          (pc_src),
        .halted          (halted)
    );

    data_path #(
        .RESET_PC (RESET_PC)
    ) i_data_path (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst            (inst),
        .alu_op          (alu_op),
        .alu_src_imm     (alu_src_imm),
        .shift_src_shamt (shift_src_shamt),
        .imm_unsigned    (imm_unsigned),
        .reg_dst_rd      (reg_dst_rd),
        .reg_we          (reg_we),
        .wb_src          (wb_src),
        .pc_src          (pc_src),
        .mem_rdata       (mem_rdata),
        .opcode          (opcode),
        .funct           (funct),
        .zero            (zero),
        .negative        (negative),
        .inst_addr       (inst_addr),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata)
    );

endmodule
